/* common/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

//////////////////////////////
// lsu sizing
//////////////////////////////

// byte address width seen by the requester
// 12 bits gives a 4 KiB data space
`define LSU_ADDR_W 12

// ram depth in 32-bit words
// two low address bits select the byte lane
`define LSU_RAM_WORDS (1 << (`LSU_ADDR_W - 2))

// word address width into the ram
`define LSU_WORD_AW (`LSU_ADDR_W - 2)

`endif

/* common/lsu_pkg.sv */
`include "lsu_config.svh"

package lsu_pkg;

  // access operation
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } mem_op_e;

  // access size, code 3 is unused and faults
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } mem_size_e;

  // handshake controller states
  // P_* on the request side, R_* on the response side
  typedef enum logic [2:0] {
    P_IDLE = 3'd0,
    P_BUSY = 3'd1,
    P_DROP = 3'd2,
    R_IDLE = 3'd3,
    R_HOLD = 3'd4,
    R_DONE = 3'd5
  } port_state_e;

  // one access from the requester
  typedef struct packed {
    mem_op_e                op;
    mem_size_e              size;
    logic                   is_signed;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [31:0]            wdata;
  } mem_req_t;

  // access after lane mapping
  typedef struct packed {
    logic                   valid;
    mem_op_e                op;
    mem_size_e              size;
    logic                   is_signed;
    logic                   fault;
    logic [`LSU_WORD_AW-1:0] word_addr;
    logic [1:0]             byte_pos;
    logic [3:0]             be;
    logic [31:0]            lane_data;
  } lane_cmd_t;

  // response back to the requester
  typedef struct packed {
    logic [31:0] rdata;
    logic        fault;
  } mem_rsp_t;

endpackage

/* logic/lsu_top.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_top (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              req_valid,
  input  lsu_pkg::mem_req_t req,
  output logic              req_ack,
  output logic              rsp_valid,
  output lsu_pkg::mem_rsp_t rsp,
  input  logic              rsp_ack
);

  // port to aligner
  logic                    issue;
  lsu_pkg::mem_req_t       held_req;
  // aligner to ram and extender
  lsu_pkg::lane_cmd_t      cmd;
  logic [3:0]              ram_we;
  logic [`LSU_WORD_AW-1:0] ram_addr;
  logic [31:0]             ram_wdata;
  // ram to extender
  logic [31:0]             ram_rdata;
  // extender back to port
  logic                    rsp_done;

  //////////////////////////////
  // request side
  //////////////////////////////

  lsu_req_port u_req_port (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req       (req),
    .req_ack   (req_ack),
    .rsp_done  (rsp_done),
    .issue     (issue),
    .held_req  (held_req)
  );

  lsu_lane_align u_lane_align (
    .clk       (clk),
    .arst_n    (arst_n),
    .issue     (issue),
    .held_req  (held_req),
    .cmd       (cmd),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata)
  );

  //////////////////////////////
  // storage and response side
  //////////////////////////////

  lsu_data_ram u_data_ram (
    .clk   (clk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  lsu_load_extend u_load_extend (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd       (cmd),
    .rdata     (ram_rdata),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ack   (rsp_ack),
    .rsp_done  (rsp_done)
  );

endmodule

/* lsu/lsu_data_ram.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_data_ram (
  input  logic                    clk,
  input  logic [3:0]              we,
  input  logic [`LSU_WORD_AW-1:0] addr,
  input  logic [31:0]             wdata,
  output logic [31:0]             rdata
);

  //////////////////////////////
  // storage
  //////////////////////////////

  // one word per entry, four byte lanes
  logic [31:0] mem [`LSU_RAM_WORDS];

  // per-lane write
  // lane i lives in bits 8*i+7 : 8*i
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < 4; i++)
    begin
      if (we[i])
        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
    end
  end

  //////////////////////////////
  // registered read
  //////////////////////////////

  // one cycle latency
  // a write to the same word in the same cycle is seen next access
  always_ff @(posedge clk)
  begin
    rdata <= mem[addr];
  end

endmodule

/* lsu/lsu_lane_align.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_lane_align (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    issue,
  input  lsu_pkg::mem_req_t       held_req,
  output lsu_pkg::lane_cmd_t      cmd,
  output logic [3:0]              ram_we,
  output logic [`LSU_WORD_AW-1:0] ram_addr,
  output logic [31:0]             ram_wdata
);

  logic        misalign;
  logic [3:0]  be_n;
  logic [31:0] lane_n;

  //////////////////////////////
  // alignment and lane mapping
  //////////////////////////////

  always_comb
  begin
    misalign = 1'b0;
    be_n     = 4'b0000;
    lane_n   = held_req.wdata;
    case (held_req.size)
      lsu_pkg::SZ_BYTE:
      begin
        // one lane, picked by addr[1:0]
        be_n   = 4'b0001 << held_req.addr[1:0];
        lane_n = {4{held_req.wdata[7:0]}};
      end
      lsu_pkg::SZ_HALF:
      begin
        // odd address faults
        misalign = held_req.addr[0];
        be_n     = held_req.addr[1] ? 4'b1100 : 4'b0011;
        lane_n   = {2{held_req.wdata[15:0]}};
      end
      lsu_pkg::SZ_WORD:
      begin
        misalign = |held_req.addr[1:0];
        be_n     = 4'b1111;
      end
      default:
      begin
        // size code 3 has no meaning, treat as fault
        misalign = 1'b1;
      end
    endcase
  end

  //////////////////////////////
  // registered lane command
  //////////////////////////////

  // valid pulses one cycle after issue
  // payload fields only move on issue
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cmd <= '0;
    end
    else
    begin
      cmd.valid <= issue;
      if (issue)
      begin
        cmd.op        <= held_req.op;
        cmd.size      <= held_req.size;
        cmd.is_signed <= held_req.is_signed;
        cmd.fault     <= misalign;
        cmd.word_addr <= held_req.addr[`LSU_ADDR_W-1:2];
        cmd.byte_pos  <= held_req.addr[1:0];
        cmd.be        <= be_n;
        cmd.lane_data <= lane_n;
      end
    end
  end

  // ram strobe only for a valid, aligned store
  assign ram_we    = (cmd.valid && cmd.op == lsu_pkg::OP_STORE && !cmd.fault) ? cmd.be : 4'b0000;
  assign ram_addr  = cmd.word_addr;
  assign ram_wdata = cmd.lane_data;

endmodule

/* lsu/lsu_load_extend.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_load_extend (
  input  logic               clk,
  input  logic               arst_n,
  input  lsu_pkg::lane_cmd_t cmd,
  input  logic [31:0]        rdata,
  output logic               rsp_valid,
  output lsu_pkg::mem_rsp_t  rsp,
  input  logic               rsp_ack,
  output logic               rsp_done
);

  lsu_pkg::lane_cmd_t   cmd_d;
  lsu_pkg::port_state_e state;
  logic [31:0]          shifted;
  logic [31:0]          load_data;

  // line cmd up with the ram read data
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      cmd_d <= '0;
    else
      cmd_d <= cmd;
  end

  //////////////////////////////
  // byte select and extend
  //////////////////////////////

  always_comb
  begin
    // addressed byte moved down to lane 0
    shifted = rdata >> {cmd_d.byte_pos, 3'b000};
    case (cmd_d.size)
      lsu_pkg::SZ_BYTE:
        load_data = {{24{cmd_d.is_signed & shifted[7]}}, shifted[7:0]};
      lsu_pkg::SZ_HALF:
        load_data = {{16{cmd_d.is_signed & shifted[15]}}, shifted[15:0]};
      default:
        load_data = rdata;
    endcase
    // stores and faults return zero
    if (cmd_d.op == lsu_pkg::OP_STORE || cmd_d.fault)
      load_data = 32'h0;
  end

  //////////////////////////////
  // response handshake
  //////////////////////////////

  // idle -> hold on aligned data, hold until ack, done until ack drops
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= lsu_pkg::R_IDLE;
      rsp_valid <= 1'b0;
      rsp_done  <= 1'b0;
    end
    else
    begin
      rsp_done <= 1'b0;
      case (state)
        lsu_pkg::R_IDLE:
        begin
          if (cmd_d.valid)
          begin
            rsp_valid <= 1'b1;
            state     <= lsu_pkg::R_HOLD;
          end
        end
        lsu_pkg::R_HOLD:
        begin
          // back-pressure, wait as long as needed
          if (rsp_ack)
          begin
            rsp_valid <= 1'b0;
            state     <= lsu_pkg::R_DONE;
          end
        end
        lsu_pkg::R_DONE:
        begin
          // falling ack closes the four-phase cycle
          if (!rsp_ack)
          begin
            rsp_done <= 1'b1;
            state    <= lsu_pkg::R_IDLE;
          end
        end
        default:
        begin
          rsp_valid <= 1'b0;
          state     <= lsu_pkg::R_IDLE;
        end
      endcase
    end
  end

  // response payload, frozen while rsp_valid is up
  always_ff @(posedge clk)
  begin
    if (state == lsu_pkg::R_IDLE && cmd_d.valid)
    begin
      rsp.rdata <= load_data;
      rsp.fault <= cmd_d.fault;
    end
  end

endmodule

/* lsu/lsu_req_port.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_req_port (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              req_valid,
  input  lsu_pkg::mem_req_t req,
  output logic              req_ack,
  input  logic              rsp_done,
  output logic              issue,
  output lsu_pkg::mem_req_t held_req
);

  lsu_pkg::port_state_e state;

  //////////////////////////////
  // request handshake
  //////////////////////////////

  // idle: wait for req_valid, then capture and ack
  // busy: ack held, waiting on response and req_valid release
  // drop: response finished, only req_valid release left
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state   <= lsu_pkg::P_IDLE;
      req_ack <= 1'b0;
      issue   <= 1'b0;
    end
    else
    begin
      // issue is a single cycle pulse
      issue <= 1'b0;
      case (state)
        lsu_pkg::P_IDLE:
        begin
          if (req_valid)
          begin
            req_ack <= 1'b1;
            issue   <= 1'b1;
            state   <= lsu_pkg::P_BUSY;
          end
        end
        lsu_pkg::P_BUSY:
        begin
          // both conditions in one cycle releases at once
          if (rsp_done && !req_valid)
          begin
            req_ack <= 1'b0;
            state   <= lsu_pkg::P_IDLE;
          end
          else if (rsp_done)
          begin
            state <= lsu_pkg::P_DROP;
          end
        end
        lsu_pkg::P_DROP:
        begin
          if (!req_valid)
          begin
            req_ack <= 1'b0;
            state   <= lsu_pkg::P_IDLE;
          end
        end
        default:
        begin
          req_ack <= 1'b0;
          state   <= lsu_pkg::P_IDLE;
        end
      endcase
    end
  end

  // request payload, loaded on acceptance only
  always_ff @(posedge clk)
  begin
    if (state == lsu_pkg::P_IDLE && req_valid)
      held_req <= req;
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator.
# Exit status is nonzero unless the log holds the pass line.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/lsu_sim

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f tb.f --top-module lsu_tb --Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
fi

if grep -qx "Test passed" "$LOG"; then
  if [ $sim_status -ne 0 ]; then
    exit 1
  fi
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi

/* tb.f */
+incdir+common
common/lsu_pkg.sv
lsu/lsu_req_port.sv
lsu/lsu_lane_align.sv
lsu/lsu_data_ram.sv
lsu/lsu_load_extend.sv
logic/lsu_top.sv
test/lsu_asserts.sv
test/lsu_tb.sv

/* test/lsu_asserts.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_asserts (
  input logic               clk,
  input logic               arst_n,
  input logic               req_valid,
  input logic               req_ack,
  input logic               rsp_valid,
  input lsu_pkg::mem_rsp_t  rsp,
  input logic               rsp_ack,
  input lsu_pkg::lane_cmd_t cmd,
  input logic [3:0]         ram_we
);

  // count of assertion failures
  int fail_count = 0;

  // misalignment from size and byte position alone
  logic bad_align;

  assign bad_align = (cmd.size == lsu_pkg::SZ_HALF && cmd.byte_pos[0]) ||
                     (cmd.size == lsu_pkg::SZ_WORD && cmd.byte_pos != 2'b00);

  //////////////////////////////
  // handshake rules
  //////////////////////////////

  // ack only in answer to a live request
  ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(req_ack) |-> $past(req_valid))
  else
  begin
    $error("req_ack rose while req_valid was low");
    fail_count++;
  end

  // response held steady under back-pressure
  rsp_held: assert property (@(posedge clk) disable iff (!arst_n)
    (rsp_valid && !rsp_ack) |=> (rsp_valid && $stable(rsp)))
  else
  begin
    $error("rsp_valid or rsp changed before rsp_ack");
    fail_count++;
  end

  //////////////////////////////
  // memory safety
  //////////////////////////////

  // misaligned access never reaches the ram
  fault_no_write: assert property (@(posedge clk) disable iff (!arst_n)
    (cmd.valid && bad_align) |-> (ram_we == 4'b0000))
  else
  begin
    $error("write enable set for a faulting command");
    fail_count++;
  end

endmodule

bind lsu_top lsu_asserts u_asserts (
  .clk       (clk),
  .arst_n    (arst_n),
  .req_valid (req_valid),
  .req_ack   (req_ack),
  .rsp_valid (rsp_valid),
  .rsp       (rsp),
  .rsp_ack   (rsp_ack),
  .cmd       (cmd),
  .ram_we    (ram_we)
);

/* test/lsu_tb.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_tb;

  logic              clk;
  logic              arst_n;
  logic              req_valid;
  lsu_pkg::mem_req_t req;
  logic              req_ack;
  logic              rsp_valid;
  lsu_pkg::mem_rsp_t rsp;
  logic              rsp_ack;

  logic [31:0] lfsr;
  // reference memory with one entry per byte address
  logic [7:0]  ref_mem [1 << `LSU_ADDR_W];

  lsu_top dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req       (req),
    .req_ack   (req_ack),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ack   (rsp_ack)
  );

  always #5 clk = ~clk;

  //////////////////////////////
  // helpers
  //////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1
  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = 32'h0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      stop_run();
    end
  endtask

  // step negedges until req_ack or rsp_valid reaches level
  task automatic wait_line(input bit pick_rsp, input logic level, input string what,
                           output int n);
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (((pick_rsp ? rsp_valid : req_ack) !== level) && n < 64);
    if ((pick_rsp ? rsp_valid : req_ack) !== level)
    begin
      $display("timeout: %s within %0d cycles", what, n);
      stop_run();
    end
  endtask

  function automatic lsu_pkg::mem_req_t make_req(
    input logic                   st,
    input logic [1:0]             sz,
    input logic                   sg,
    input logic [`LSU_ADDR_W-1:0] a,
    input logic [31:0]            wd
  );
    lsu_pkg::mem_req_t r;
    r.op        = st ? lsu_pkg::OP_STORE : lsu_pkg::OP_LOAD;
    r.size      = lsu_pkg::mem_size_e'(sz);
    r.is_signed = sg;
    r.addr      = a;
    r.wdata     = wd;
    return r;
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  // little endian
  // byte i of a word sits in lane i
  task automatic model_access(input lsu_pkg::mem_req_t r, output logic [31:0] data,
                              output logic fault);
    logic [31:0]            word;
    logic [`LSU_ADDR_W-1:0] a;
    int                     nbytes;
    nbytes = (r.size == lsu_pkg::SZ_BYTE) ? 1 : (r.size == lsu_pkg::SZ_HALF) ? 2 : 4;
    fault  = (r.size == lsu_pkg::SZ_HALF && r.addr[0]) ||
             (r.size == lsu_pkg::SZ_WORD && r.addr[1:0] != 2'b00);
    data   = 32'h0;
    word   = 32'h0;
    a      = r.addr;
    if (!fault)
    begin
      for (int i = 0; i < nbytes; i++)
      begin
        if (r.op == lsu_pkg::OP_STORE)
          ref_mem[a] = r.wdata[8*i +: 8];
        else
          word[8*i +: 8] = ref_mem[a];
        a = a + 1'b1;
      end
      if (r.op == lsu_pkg::OP_LOAD)
      begin
        // unused upper bytes are already zero
        data = word;
        if (r.is_signed && r.size == lsu_pkg::SZ_BYTE && word[7])
          data = word | 32'hffffff00;
        if (r.is_signed && r.size == lsu_pkg::SZ_HALF && word[15])
          data = word | 32'hffff0000;
      end
    end
  endtask

  // one full access over both four-phase handshakes
  task automatic do_access(input string name, input lsu_pkg::mem_req_t r, input int ack_delay);
    logic [31:0] exp_data;
    logic        exp_fault;
    int          n;
    model_access(r, exp_data, exp_fault);
    req       = r;
    req_valid = 1'b1;
    wait_line(1'b0, 1'b1, "req_ack never rose", n);
    req_valid = 1'b0;
    // response three cycles after the ack
    wait_line(1'b1, 1'b1, "rsp_valid never rose", n);
    check_val({name, " latency"}, 32'd3, 32'(n));
    check_val({name, " rdata"}, exp_data, rsp.rdata);
    check_val({name, " fault"}, 32'(exp_fault), 32'(rsp.fault));
    repeat (ack_delay) @(negedge clk);
    rsp_ack = 1'b1;
    wait_line(1'b1, 1'b0, "rsp_valid never fell after rsp_ack", n);
    rsp_ack = 1'b0;
    wait_line(1'b0, 1'b0, "req_ack never fell after the response", n);
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial
  begin
    logic [31:0]            t;
    logic [31:0]            w;
    logic [1:0]             sz;
    logic [`LSU_ADDR_W-1:0] a;
    logic [`LSU_ADDR_W-1:0] la;
    logic [`LSU_ADDR_W-1:0] aq[$];
    clk       = 1'b0;
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ack   = 1'b0;
    lfsr      = 32'hfc671e79;
    // reset then quiet until the first request
    repeat (8)
    begin
      @(negedge clk);
      check_val("reset req_ack", 32'd0, 32'(req_ack));
      check_val("reset rsp_valid", 32'd0, 32'(rsp_valid));
    end
    arst_n = 1'b1;
    repeat (4)
    begin
      @(negedge clk);
      check_val("idle req_ack", 32'd0, 32'(req_ack));
      check_val("idle rsp_valid", 32'd0, 32'(rsp_valid));
    end
    // fill every word with a pattern hashed from the word index
    for (int k = 0; k < `LSU_RAM_WORDS; k++)
    begin
      a = {k[`LSU_WORD_AW-1:0], 2'b00};
      w = (32'(k) * 32'h9e3779b1) ^ 32'h0f0fa5a5;
      do_access("fill", make_req(1'b1, lsu_pkg::SZ_WORD, 1'b0, a, w), 0);
    end
    // word round trip
    for (int i = 0; i < 16; i++)
    begin
      t = rand_bits(`LSU_ADDR_W);
      a = {t[`LSU_ADDR_W-1:2], 2'b00};
      aq.push_back(a);
      do_access("word store", make_req(1'b1, lsu_pkg::SZ_WORD, 1'b0, a, rand_bits(32)), 1);
    end
    foreach (aq[i])
      do_access("word load", make_req(1'b0, lsu_pkg::SZ_WORD, 1'b0, aq[i], 32'h0), 2);
    // byte lanes with the sign bit alternating per lane
    t = rand_bits(`LSU_ADDR_W);
    a = {t[`LSU_ADDR_W-1:2], 2'b00};
    for (int i = 0; i < 4; i++)
    begin
      w    = rand_bits(8);
      w[7] = i[0];
      la   = {a[`LSU_ADDR_W-1:2], i[1:0]};
      do_access("byte store", make_req(1'b1, lsu_pkg::SZ_BYTE, 1'b0, la, w), 0);
    end
    do_access("merged word", make_req(1'b0, lsu_pkg::SZ_WORD, 1'b0, a, 32'h0), 0);
    for (int i = 0; i < 8; i++)
    begin
      la = {a[`LSU_ADDR_W-1:2], i[1:0]};
      do_access("byte load", make_req(1'b0, lsu_pkg::SZ_BYTE, i[2], la, 32'h0), i % 4);
    end
    // halves at offsets 0 and 2
    // each offset sees both values of the sign bit
    for (int i = 0; i < 4; i++)
    begin
      w     = rand_bits(16);
      w[15] = i[1];
      la    = {a[`LSU_ADDR_W-1:2], i[0], 1'b0};
      do_access("half store", make_req(1'b1, lsu_pkg::SZ_HALF, 1'b0, la, w), 0);
      do_access("half load u", make_req(1'b0, lsu_pkg::SZ_HALF, 1'b0, la, 32'h0), 1);
      do_access("half load s", make_req(1'b0, lsu_pkg::SZ_HALF, 1'b1, la, 32'h0), 3);
    end
    do_access("half merge", make_req(1'b0, lsu_pkg::SZ_WORD, 1'b0, a, 32'h0), 0);
    // misaligned word and half accesses leave memory untouched
    for (int i = 1; i < 4; i++)
    begin
      la = {a[`LSU_ADDR_W-1:2], i[1:0]};
      do_access("misalign word st", make_req(1'b1, lsu_pkg::SZ_WORD, 1'b0, la, 32'hffffffff), 0);
      do_access("misalign word ld", make_req(1'b0, lsu_pkg::SZ_WORD, 1'b1, la, 32'h0), 0);
      if (i[0])
      begin
        do_access("misalign half st", make_req(1'b1, lsu_pkg::SZ_HALF, 1'b0, la, 32'hffff), 0);
        do_access("misalign half ld", make_req(1'b0, lsu_pkg::SZ_HALF, 1'b1, la, 32'h0), 0);
      end
    end
    do_access("after misalign", make_req(1'b0, lsu_pkg::SZ_WORD, 1'b0, a, 32'h0), 0);
    // random mix with half of it packed into a 64 byte window
    for (int i = 0; i < 300; i++)
    begin
      t  = rand_bits(8);
      sz = (t[2:1] == 2'b11) ? 2'b10 : t[2:1];
      w  = rand_bits(`LSU_ADDR_W);
      a  = w[`LSU_ADDR_W-1:0];
      if (t[4])
        a[`LSU_ADDR_W-1:6] = '0;
      do_access("random", make_req(t[0], sz, t[3], a, rand_bits(32)), int'(t[7:5]));
    end
    if (dut.u_asserts.fail_count != 0)
    begin
      $display("handshake assertions failed %0d times", dut.u_asserts.fail_count);
      stop_run();
    end
    else
    begin
      $display("Test passed");
      $finish;
    end
  end

endmodule
